// File: rtl/vic_pkg.sv
package vic_pkg;

    // 6567R56A frame geometry
    localparam int cycles_per_line = 64;
    localparam int dots_per_cycle  = 8;
    localparam int dots_per_line   = cycles_per_line * dots_per_cycle;  // 512 dots
    localparam int lines_per_frame = 262;
    localparam int clks_per_dot    = 4;                                 // clk_dot4x per dot
    localparam int clks_per_cycle  = clks_per_dot * dots_per_cycle;     // 32 clocks
    localparam int clks_per_half   = clks_per_cycle / 2;                // video or cpu half

    // strobe positions
    localparam int ras_fall_clk   = 2;   // within each half
    localparam int cas_fall_clk   = 4;   // within each half
    localparam int cpu_strobe_clk = 28;  // clock in the cycle, late in cpu half

    // composite sync, dots and lines
    localparam int hsync_start = 400;
    localparam int hsync_end   = 440;   // exclusive
    localparam int vsync_start = 14;
    localparam int vsync_end   = 17;    // exclusive

    // display window, inclusive limits
    localparam int win_x_first = 24;
    localparam int win_x_last  = 343;
    localparam int win_y_first = 51;
    localparam int win_y_last  = 250;

    // register index on ad[5:0]
    localparam logic [5:0] reg_control    = 6'h11;
    localparam logic [5:0] reg_raster     = 6'h12;
    localparam logic [5:0] reg_irq_flag   = 6'h19;
    localparam logic [5:0] reg_irq_enable = 6'h1A;
    localparam logic [5:0] reg_border     = 6'h20;
    localparam logic [5:0] reg_background = 6'h21;

    // bit positions
    localparam int ctrl_raster8   = 7;  // compare / raster bit 8
    localparam int ctrl_den       = 4;  // display enable
    localparam int irq_raster_bit = 0;  // flag and enable
    localparam int irq_any_bit    = 7;  // flag readback, irq pin active

    // color registers, low nibble only
    typedef struct packed {
        logic [3:0] rsvd;
        logic [3:0] index;
    } color_view_t;

    // flag bits by name, same layout for control, flag and enable
    typedef struct packed {
        logic       raster8;     // bit 7
        logic [1:0] rsvd6_5;
        logic       den;         // bit 4
        logic [2:0] rsvd3_1;
        logic       irq_raster;  // bit 0
    } ctrl_view_t;

    typedef union packed {
        color_view_t color;
        ctrl_view_t  ctrl;
    } reg_word_t;

endpackage : vic_pkg

// File: rtl/bus_phase_fsm.sv
`timescale 1ns/100ps

module bus_phase_fsm (
    input  logic clk_dot4x,
    input  logic rst_n,
    input  logic ce,           // low = chip selected
    input  logic rw,           // high = read
    output logic clk_phi,
    output logic aec,
    output logic ba,
    output logic ras,
    output logic cas,
    output logic den_n,
    output logic dir,
    output logic cycle_start,  // clock 0 of each bus cycle
    output logic dot_tick,     // once per dot
    output logic cpu_strobe    // cpu access sample point
);
    import vic_pkg::*;

    typedef enum logic {video_half, cpu_half} phase_t;

    phase_t     state;
    phase_t     state_nxt;
    logic [4:0] cnt;        // clock within the bus cycle
    logic [4:0] cnt_nxt;
    logic [3:0] half_nxt;   // clock within the half, next value

    always_comb begin
        cnt_nxt   = (cnt == 5'(clks_per_cycle - 1)) ? 5'd0 : cnt + 5'd1;
        half_nxt  = 4'(cnt_nxt % clks_per_half);
        state_nxt = state;
        case (state)
            video_half: if (cnt == 5'(clks_per_half - 1)) state_nxt = cpu_half;
            cpu_half:   if (cnt == 5'(clks_per_cycle - 1)) state_nxt = video_half;
            default:    state_nxt = video_half;
        endcase
    end

    // strobes registered from the next count, glitch free on the pins
    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            state   <= video_half;
            cnt     <= '0;
            clk_phi <= 1'b0;
            aec     <= 1'b0;
            ba      <= 1'b0;   // only low while in reset
            ras     <= 1'b1;
            cas     <= 1'b1;
        end else begin
            state   <= state_nxt;
            cnt     <= cnt_nxt;
            clk_phi <= (state_nxt == cpu_half);
            aec     <= (state_nxt == cpu_half);   // no fetches, cpu owns its half
            ba      <= 1'b1;                      // never stalls the cpu
            ras     <= (half_nxt < 4'(ras_fall_clk));
            cas     <= (half_nxt < 4'(cas_fall_clk));
        end
    end

    assign den_n       = ~(clk_phi & ~ce);        // transceiver on during cpu access
    assign dir         = rw;                      // read drives toward cpu
    assign cycle_start = (cnt == 5'd0);
    assign dot_tick    = ((cnt % clks_per_dot) == 0);
    assign cpu_strobe  = (state == cpu_half) && (cnt == 5'(cpu_strobe_clk));

    // row strobe leads column strobe in both halves
    a_ras_before_cas: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
        $fell(ras) |-> cas);

    // phase flips only where the counter enters a half
    a_phi_at_half_edge: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
        $changed(clk_phi) |-> ((cnt == 5'd0) || (cnt == 5'(clks_per_half))));

endmodule : bus_phase_fsm

// File: rtl/raster_counter.sv
`timescale 1ns/100ps

module raster_counter (
    input  logic       clk_dot4x,
    input  logic       rst_n,
    input  logic       dot_tick,    // from phase sequencer
    output logic [8:0] raster_x,    // dot within line
    output logic [8:0] raster_y,    // line within frame
    output logic       line_start   // first dot of a line
);
    import vic_pkg::*;

    logic x_wrap;   // last dot of the line
    logic y_wrap;   // last line of the frame

    assign x_wrap = (raster_x == 9'(dots_per_line - 1));
    assign y_wrap = (raster_y == 9'(lines_per_frame - 1));

    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            raster_x <= '0;
            raster_y <= '0;
        end else if (dot_tick) begin
            if (x_wrap) begin
                raster_x <= '0;
                raster_y <= y_wrap ? 9'd0 : raster_y + 9'd1;   // new line
            end else begin
                raster_x <= raster_x + 9'd1;
            end
        end
    end

    assign line_start = (raster_x == 9'd0);

    // 262 lines, the 9-bit counter has room past the frame
    a_raster_y_range: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
        raster_y < 9'(lines_per_frame));

endmodule : raster_counter

// File: rtl/vic_registers.sv
`timescale 1ns/100ps

module vic_registers (
    input  logic       clk_dot4x,
    input  logic       rst_n,
    input  logic       cpu_strobe,         // access point in cpu half
    input  logic       ce,                 // low = selected
    input  logic       rw,                 // high = read
    input  logic [5:0] reg_addr,           // from ad[5:0]
    input  logic [7:0] wdata,              // from db[7:0]
    input  logic [8:0] raster_y,
    input  logic       line_start,
    output logic [7:0] rdata,
    output logic       irq,                // active low
    output logic [3:0] border_color,
    output logic [3:0] background_color,
    output logic       den
);
    import vic_pkg::*;

    reg_word_t  wd;           // write byte, color or flag view
    logic       wr_en;
    logic       rd_en;
    logic [8:0] raster_cmp;   // irq compare line
    logic       cmp_hit;
    logic       irq_flag;
    logic       irq_en;
    logic [7:0] rd_mux;

    assign wd      = reg_word_t'(wdata);
    assign wr_en   = cpu_strobe && !ce && !rw;
    assign rd_en   = cpu_strobe && !ce && rw;
    assign cmp_hit = line_start && (raster_y == raster_cmp);

    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            border_color     <= '0;   // black
            background_color <= '0;
            den              <= 1'b0;
            raster_cmp       <= '0;
            irq_flag         <= 1'b0;
            irq_en           <= 1'b0;
        end else begin
            if (wr_en) begin
                case (reg_addr)
                    reg_control: begin
                        raster_cmp[8] <= wd.ctrl.raster8;
                        den           <= wd.ctrl.den;
                    end
                    reg_raster:     raster_cmp[7:0]  <= wdata;
                    reg_irq_enable: irq_en           <= wd.ctrl.irq_raster;
                    reg_border:     border_color     <= wd.color.index;
                    reg_background: background_color <= wd.color.index;
                    default: ;
                endcase
            end
            // compare match wins over a clear on the same clock
            if (cmp_hit) begin
                irq_flag <= 1'b1;
            end else if (wr_en && (reg_addr == reg_irq_flag) && wd.ctrl.irq_raster) begin
                irq_flag <= 1'b0;   // write 1 to clear
            end
        end
    end

    assign irq = ~(irq_flag & irq_en);

    always_comb begin
        rd_mux = 8'h00;
        case (reg_addr)
            reg_control: begin
                rd_mux[ctrl_raster8] = raster_y[8];   // live raster, not compare
                rd_mux[ctrl_den]     = den;
            end
            reg_raster: rd_mux = raster_y[7:0];
            reg_irq_flag: begin
                rd_mux[irq_raster_bit] = irq_flag;
                rd_mux[irq_any_bit]    = ~irq;        // pin state
            end
            reg_irq_enable: rd_mux[irq_raster_bit] = irq_en;
            reg_border:     rd_mux = {4'h0, border_color};
            reg_background: rd_mux = {4'h0, background_color};
            default:        rd_mux = 8'hFF;           // unmapped
        endcase
    end

    // captured at the strobe, held to end of cpu half
    always_ff @(posedge clk_dot4x) begin
        if (rd_en) begin
            rdata <= rd_mux;
        end
    end

    a_rdata_known: assert property (@(posedge clk_dot4x) disable iff (!rst_n)
        rd_en |=> !$isunknown(rdata));

endmodule : vic_registers

// File: rtl/video_output.sv
`timescale 1ns/100ps

module video_output (
    input  logic       clk_dot4x,
    input  logic       rst_n,
    input  logic [8:0] raster_x,
    input  logic [8:0] raster_y,
    input  logic       den,               // display enable
    input  logic [3:0] border_color,
    input  logic [3:0] background_color,
    output logic       csync,             // composite, active low
    output logic [1:0] red,
    output logic [1:0] green,
    output logic [1:0] blue
);
    import vic_pkg::*;

    logic       hsync;
    logic       vsync;
    logic       in_win;      // inside display window
    logic [3:0] color_idx;
    logic [5:0] rgb;         // {r, g, b}

    // 16 entry palette, overlapping index bits per channel
    function automatic logic [5:0] palette(input logic [3:0] idx);
        return {idx[3:2], idx[2:1], idx[1:0]};
    endfunction

    assign hsync = (raster_x >= 9'(hsync_start)) && (raster_x < 9'(hsync_end));
    assign vsync = (raster_y >= 9'(vsync_start)) && (raster_y < 9'(vsync_end));

    assign in_win = (raster_x >= 9'(win_x_first)) && (raster_x <= 9'(win_x_last)) &&
                    (raster_y >= 9'(win_y_first)) && (raster_y <= 9'(win_y_last));

    assign color_idx = (in_win && den) ? background_color : border_color;
    assign rgb       = palette(color_idx);

    // one clock behind the dot position
    always_ff @(posedge clk_dot4x) begin
        if (!rst_n) begin
            csync <= 1'b1;
            red   <= 2'b00;
            green <= 2'b00;
            blue  <= 2'b00;
        end else begin
            csync <= ~(hsync | vsync);   // vsync holds the whole line low
            red   <= rgb[5:4];
            green <= rgb[3:2];
            blue  <= rgb[1:0];
        end
    end

endmodule : video_output

// File: rtl/vic_top.sv
`timescale 1ns/100ps

module vic_top (
    input  logic        clk_dot4x,   // 4x dot clock from board
    output logic        clk_phi,     // cpu clock
    output logic        cSync,
    output logic [1:0]  red,
    output logic [1:0]  green,
    output logic [1:0]  blue,
    inout  wire  [11:0] ad,          // register index in 5:0
    inout  wire  [11:0] db,          // data in 7:0
    input  logic        ce,          // low = selected
    input  logic        rw,          // high = read
    input  logic        rst_n,
    output logic        irq,
    output logic        aec,
    output logic        ba,
    output logic        cas,
    output logic        ras,
    output logic        den_n,
    output logic        dir
);

    logic       dot_tick;
    logic       cpu_strobe;
    logic [8:0] raster_x;
    logic [8:0] raster_y;
    logic       line_start;
    logic [7:0] rdata;
    logic [3:0] border_color;
    logic [3:0] background_color;
    logic       den;

    bus_phase_fsm u_phase (
        .clk_dot4x(clk_dot4x), .rst_n(rst_n), .ce(ce), .rw(rw),
        .clk_phi(clk_phi), .aec(aec), .ba(ba), .ras(ras), .cas(cas),
        .den_n(den_n), .dir(dir), .cycle_start(),
        .dot_tick(dot_tick), .cpu_strobe(cpu_strobe)
    );

    raster_counter u_raster (
        .clk_dot4x(clk_dot4x), .rst_n(rst_n), .dot_tick(dot_tick),
        .raster_x(raster_x), .raster_y(raster_y), .line_start(line_start)
    );

    vic_registers u_regs (
        .clk_dot4x(clk_dot4x), .rst_n(rst_n), .cpu_strobe(cpu_strobe),
        .ce(ce), .rw(rw), .reg_addr(ad[5:0]), .wdata(db[7:0]),
        .raster_y(raster_y), .line_start(line_start), .rdata(rdata),
        .irq(irq), .border_color(border_color),
        .background_color(background_color), .den(den)
    );

    video_output u_video (
        .clk_dot4x(clk_dot4x), .rst_n(rst_n), .raster_x(raster_x),
        .raster_y(raster_y), .den(den), .border_color(border_color),
        .background_color(background_color), .csync(cSync),
        .red(red), .green(green), .blue(blue)
    );

    // read data onto db during a selected cpu read, else released
    assign db = (aec && rw && !ce) ? {4'h0, rdata} : 12'bz;
    assign ad = 12'bz;   // no memory fetches, ad is input only

endmodule : vic_top

// File: test/tb_vic_top.sv
`timescale 1ns/100ps

module tb_vic_top;
    import vic_pkg::*;

    localparam int clk_half_ns    = 20;                                // 40 ns period
    localparam int clks_per_line  = dots_per_line * clks_per_dot;      // 2048 clocks
    localparam int hsync_clks     = (hsync_end - hsync_start) * clks_per_dot;
    localparam int vsync_clks     = (vsync_end - vsync_start) * clks_per_line;
    localparam longint frame_clks = longint'(clks_per_line) * lines_per_frame;
    localparam longint wdog_ns    = (3 * frame_clks + 100000) * 2 * clk_half_ns;

    logic        clk_dot4x;
    logic        rst_n;
    logic        ce;
    logic        rw;
    logic [11:0] ad_drv;
    logic [7:0]  db_drv;
    logic        db_oe;        // tb drives db on writes
    wire  [11:0] ad;
    wire  [11:0] db;
    logic        clk_phi;
    logic        cSync;
    logic [1:0]  red;
    logic [1:0]  green;
    logic [1:0]  blue;
    logic        irq;
    logic        aec;
    logic        ba;
    logic        cas;
    logic        ras;
    logic        den_n;
    logic        dir;

    int          errors = 0;
    logic        run_checks = 1'b0;  // monitors on after reset
    int          half_pos = -1;      // clock within the aec half, -1 until an aec edge
    logic        aec_q = 1'b0;
    int          track_line = 0;     // line of the last csync falling edge
    int          edges = 0;          // falling edges since last vsync
    int          low_len = 0;        // csync low time in clocks
    logic        synced = 1'b0;      // a vsync has been seen
    logic        csync_q = 1'b1;
    event        line_fell;
    int unsigned seed_val;

    assign ad = ad_drv;
    assign db = db_oe ? {4'h0, db_drv} : 12'bz;

    vic_top u_dut (
        .clk_dot4x(clk_dot4x), .clk_phi(clk_phi), .cSync(cSync),
        .red(red), .green(green), .blue(blue), .ad(ad), .db(db),
        .ce(ce), .rw(rw), .rst_n(rst_n), .irq(irq), .aec(aec), .ba(ba),
        .cas(cas), .ras(ras), .den_n(den_n), .dir(dir)
    );

    initial begin
        clk_dot4x = 1'b0;
        forever #(clk_half_ns) clk_dot4x = ~clk_dot4x;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got %0h, expected %0h at %0t", name, got, exp, $time);
            errors++;
        end
    endtask

    // one bus cycle, processor half only
    task automatic bus_access(input logic [5:0] addr, input logic is_read,
                              input logic [7:0] wdata, output logic [7:0] rd);
        @(posedge aec);
        #2;
        ad_drv = {6'h0, addr};
        rw     = is_read;
        ce     = 1'b0;
        db_drv = wdata;
        db_oe  = !is_read;
        repeat (14) @(posedge clk_dot4x);   // past strobe at clock 28
        @(negedge clk_dot4x);
        rd = db[7:0];                       // read data held to end of half
        @(negedge aec);
        #2;
        ce    = 1'b1;
        rw    = 1'b1;
        db_oe = 1'b0;
    endtask

    // edge of line n-1 sits at hsync start, then move to mid-line n
    task automatic wait_line(input int n);
        int prev;
        prev = (n == 0) ? lines_per_frame - 1 : n - 1;
        do @(line_fell); while (!(synced && track_line == prev));
        repeat ((dots_per_line - hsync_start + 150) * clks_per_dot) @(posedge clk_dot4x);
    endtask

    task automatic play_file();
        int             fd;
        int             rc;
        reg [8*8-1:0]   cmd;
        reg [8*200-1:0] rest;
        logic [31:0]    a;
        logic [31:0]    b;
        logic [31:0]    c;
        logic [31:0]    d;
        logic [7:0]     rd;
        logic [7:0]     wd;
        fd = $fopen("test/vic_testdata.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file test/vic_testdata.txt");
            errors++;
        end else begin
            while ($fscanf(fd, "%s", cmd) == 1) begin
                if (cmd == "#") begin
                    rc = $fgets(rest, fd);          // comment line
                end else if (cmd == "W") begin
                    rc = $fscanf(fd, "%h %h", a, b);
                    bus_access(a[5:0], 1'b0, b[7:0], rd);
                end else if (cmd == "R") begin
                    rc = $fscanf(fd, "%h %h", a, b);
                    bus_access(a[5:0], 1'b1, 8'h00, rd);
                    check_value($sformatf("db reg %02h", a[5:0]), rd, b[7:0]);
                end else if (cmd == "X") begin
                    rc = $fscanf(fd, "%h %h", a, b);
                    wd = 8'($urandom);
                    bus_access(a[5:0], 1'b0, wd, rd);
                    bus_access(a[5:0], 1'b1, 8'h00, rd);
                    check_value($sformatf("db reg %02h", a[5:0]), rd, wd & b[7:0]);
                end else if (cmd == "L") begin
                    rc = $fscanf(fd, "%d", a);
                    wait_line(a);
                end else if (cmd == "C") begin
                    rc = $fscanf(fd, "%d %d %d %d", a, b, c, d);
                    @(posedge aec);                   // sample in processor half
                    repeat (4) @(posedge clk_dot4x);
                    @(negedge clk_dot4x);
                    check_value("red", red, a);
                    check_value("green", green, b);
                    check_value("blue", blue, c);
                    check_value("cSync", cSync, d);
                end else if (cmd == "I") begin
                    rc = $fscanf(fd, "%d", a);
                    @(negedge clk_dot4x);
                    check_value("irq", irq, a);
                end else begin
                    $display("Unknown command %0s in the stimulus file", cmd);
                    errors++;
                end
            end
            $fclose(fd);
        end
    endtask

    // phase and strobe rules, mid-period
    always @(negedge clk_dot4x) begin
        if (run_checks) begin
            check_value("aec", aec, clk_phi);
            check_value("ba", ba, 1'b1);
            check_value("den_n", den_n, !(aec && !ce));
            if (!ce) check_value("dir", dir, rw);
            if (aec !== aec_q) half_pos = 0;              // new half
            else if (half_pos >= 0) half_pos = half_pos + 1;
            aec_q = aec;
            if (half_pos >= 0) begin
                check_value("ras", ras, (half_pos < ras_fall_clk) ? 1'b1 : 1'b0);
                check_value("cas", cas, (half_pos < cas_fall_clk) ? 1'b1 : 1'b0);
            end
        end
    end

    // line tracker from csync alone
    always @(negedge clk_dot4x) begin
        if (run_checks) begin
            if (!cSync) low_len = low_len + 1;
            if (csync_q && !cSync && synced) begin
                track_line = (track_line == lines_per_frame - 1) ? 0 : track_line + 1;
                edges      = edges + 1;
                -> line_fell;
            end
            if (!csync_q && cSync) begin
                if (low_len > clks_per_line) begin            // vsync
                    check_value("vsync_low", low_len, vsync_clks);
                    if (synced) check_value("frame_lines", edges + 2, lines_per_frame);
                    synced     = 1'b1;
                    track_line = vsync_end - 1;   // lines 15, 16 give no edge
                    edges      = 0;
                end else begin
                    check_value("hsync_low", low_len, hsync_clks);
                end
                low_len = 0;
            end
            csync_q = cSync;
        end
    end

    initial begin
        #(wdog_ns);
        $display("Timeout: the run took longer than three frames");
        $display("Checks failed");
        $finish;
    end

    initial begin
        rst_n    = 1'b0;
        ce       = 1'b1;
        rw       = 1'b1;
        ad_drv   = 12'h000;
        db_drv   = 8'h00;
        db_oe    = 1'b0;
        seed_val = $urandom(32'h41d51f7d);
        repeat (5) @(posedge clk_dot4x);
        #2 rst_n = 1'b1;
        @(posedge clk_dot4x);
        @(negedge clk_dot4x);
        check_value("irq", irq, 1'b1);      // reset state
        check_value("ras", ras, 1'b1);
        check_value("cas", cas, 1'b1);
        check_value("den_n", den_n, 1'b1);
        check_value("red", red, 2'b00);
        check_value("green", green, 2'b00);
        check_value("blue", blue, 2'b00);
        run_checks = 1'b1;
        play_file();
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule : tb_vic_top

// File: test/vic_testdata.txt
# columns: W addr data | R addr expect | X addr mask (random write and readback)
# L line (wait to mid-line) | C red green blue csync | I irq, addr and data in hex
# register readback
W 20 5A
R 20 0A
W 21 C3
R 21 03
W 1A FF
R 1A 01
R 3F FF
R 00 FF
X 20 0F
X 21 0F
X 1A 01
W 1A 00
# colors, border 0xE and background 0x5
W 20 0E
W 21 05
W 11 10
L 100
C 1 2 1 1
L 30
C 3 3 2 1
W 11 00
L 100
C 3 3 2 1
# raster interrupt at line 120
W 12 78
W 11 10
W 19 01
W 1A 01
I 1
L 120
I 0
R 19 81
W 19 01
I 1
R 19 00

// File: sim.f
rtl/vic_pkg.sv
rtl/bus_phase_fsm.sv
rtl/raster_counter.sv
rtl/vic_registers.sv
rtl/video_output.sv
rtl/vic_top.sv
test/tb_vic_top.sv

// File: Bender.yml
package:
  name: vic_video

sources:
  - rtl/vic_pkg.sv
  - rtl/bus_phase_fsm.sv
  - rtl/raster_counter.sv
  - rtl/vic_registers.sv
  - rtl/video_output.sv
  - rtl/vic_top.sv
  - target: test
    files:
      - test/tb_vic_top.sv
